// File: logic/fetch_pkg.sv
////////////////////////////////////////////////////////////////////////////
// widths, memory depth, nop and jal encodings, instruction word views
////////////////////////////////////////////////////////////////////////////

package fetch_pkg;

    ////////////////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////////////////

    localparam int xlen           = 32;                 // pc and address width
    localparam int imem_lines     = 64;                 // 64-bit lines, two insts each
    localparam int imem_addr_bits = $clog2(imem_lines); // line index width

    ////////////////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////////////////

    // addi x0,x0,0 fills bubbles and squashed slots
    localparam logic [31:0] nop_inst   = 32'h0000_0013;
    localparam logic [6:0]  opcode_jal = 7'b110_1111;   // jal rd,imm

    // register-type field layout, used here only for the opcode
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    // jump-type layout, immediate bits are scattered across the word
    typedef struct packed {
        logic       imm20;      // sign bit
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;         // link register
        logic [6:0] opcode;
    } inst_j_t;

    // same 32 bits seen two ways
    typedef union packed {
        inst_r_t r;
        inst_j_t j;
    } inst_word_u;

endpackage

// File: logic/imem.sv
////////////////////////////////////////////////////////////////////////////
// instruction memory, 64-bit lines, combinational read, load port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module imem (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                load_enable, // write one line
    input  logic [fetch_pkg::imem_addr_bits-1:0] load_addr,  // line index
    input  logic [63:0]                         load_data,   // whole line
    input  logic [fetch_pkg::xlen-1:0]          addr,        // byte address
    output logic [63:0]                         data         // line at addr
);

    logic [63:0]                          lines [fetch_pkg::imem_lines]; // no reset
    logic [fetch_pkg::imem_addr_bits-1:0] line_index;

    // byte address -> line, bits [2:0] pick a byte inside the line
    assign line_index = addr[fetch_pkg::imem_addr_bits+2:3];

    ////////////////////////////////////////////////////////////////////////
    // fill port
    ////////////////////////////////////////////////////////////////////////

    // program image goes in while the core sits in reset,
    // after that the array is read only
    always_ff @(posedge clock) begin
        if (load_enable && reset) begin
            lines[load_addr] <= load_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // read port
    ////////////////////////////////////////////////////////////////////////

    // same-cycle read so fetch sees data with the address
    assign data = lines[line_index];

endmodule

// File: logic/stage_if.sv
////////////////////////////////////////////////////////////////////////////
// fetch stage: program counter, line half select, if/id packet register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module stage_if (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       stall,         // hold pc, send bubbles
    input  logic                       stall_load,    // freeze the packet
    input  logic                       take_branch,   // redirect from decode
    input  logic [fetch_pkg::xlen-1:0] branch_target, // new pc when taken
    input  logic [63:0]                imem_data,     // line from memory
    output logic [fetch_pkg::xlen-1:0] imem_addr,     // line aligned pc
    output logic                       if_valid,
    output logic [fetch_pkg::xlen-1:0] if_pc,
    output logic [fetch_pkg::xlen-1:0] if_npc,
    output logic [31:0]                if_inst
);

    logic [fetch_pkg::xlen-1:0] pc_reg;      // address being fetched now
    logic [fetch_pkg::xlen-1:0] pc_plus4;
    logic [31:0]                fetch_inst;  // selected half of the line

    assign pc_plus4 = pc_reg + fetch_pkg::xlen'(4);

    // bit 2 picks the upper word of the 8-byte line
    assign fetch_inst = pc_reg[2] ? imem_data[63:32] : imem_data[31:0];

    // memory only sees whole lines
    assign imem_addr = {pc_reg[fetch_pkg::xlen-1:3], 3'b000};

    // program counter
    always_ff @(posedge clock) begin
        if (reset) begin
            pc_reg <= '0;                 // program starts at 0
        end else if (take_branch) begin
            pc_reg <= branch_target;      // redirect wins over any stall
        end else if (!stall) begin
            pc_reg <= pc_plus4;
        end
    end

    // if/id packet
    always_ff @(posedge clock) begin
        if (reset || take_branch) begin   // squash to an invalid nop
            if_valid <= 1'b0;
            if_inst  <= fetch_pkg::nop_inst;
            if_pc    <= '0;
            if_npc   <= fetch_pkg::xlen'(4);
        end else if (!stall_load) begin   // stall_load keeps the old packet
            if_valid <= !stall;
            if_inst  <= stall ? fetch_pkg::nop_inst : fetch_inst; // bubble on stall
            if_pc    <= pc_reg;
            if_npc   <= pc_plus4;
        end
    end

endmodule

// File: logic/stage_id_predecode.sv
////////////////////////////////////////////////////////////////////////////
// decode front: id register, jal detect, jump target, redirect merge
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module stage_id_predecode (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       stall_load,      // freeze id register
    input  logic                       redirect,        // from a later stage
    input  logic [fetch_pkg::xlen-1:0] redirect_target,
    input  logic                       if_valid,        // packet from fetch
    input  logic [fetch_pkg::xlen-1:0] if_pc,
    input  logic [fetch_pkg::xlen-1:0] if_npc,
    input  logic [31:0]                if_inst,
    output logic                       id_valid,
    output logic [fetch_pkg::xlen-1:0] id_pc,
    output logic [fetch_pkg::xlen-1:0] id_npc,
    output logic [31:0]                id_inst,
    output logic                       take_branch,     // to fetch, also squashes here
    output logic [fetch_pkg::xlen-1:0] branch_target
);

    fetch_pkg::inst_word_u      id_word;     // id_inst seen through both views
    logic                       is_jal;
    logic                       jal_taken;
    logic [fetch_pkg::xlen-1:0] jal_offset;  // sign extended j-immediate
    logic [fetch_pkg::xlen-1:0] jal_target;

    ////////////////////////////////////////////////////////////////////////
    // id pipeline register
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || take_branch) begin
            // whatever sits here is on the wrong path
            id_valid <= 1'b0;
            id_inst  <= fetch_pkg::nop_inst;
            id_pc    <= '0;
            id_npc   <= fetch_pkg::xlen'(4);
        end else if (!stall_load) begin   // hold while a load is pending
            id_valid <= if_valid;
            id_inst  <= if_inst;
            id_pc    <= if_pc;
            id_npc   <= if_npc;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // jal predecode
    ////////////////////////////////////////////////////////////////////////

    assign id_word = id_inst;

    // opcode sits at the same bits in every format
    assign is_jal    = (id_word.r.opcode == fetch_pkg::opcode_jal);
    assign jal_taken = id_valid && is_jal;         // bubbles never jump

    // imm[20|10:1|11|19:12], bit 0 always zero
    assign jal_offset = {
        {(fetch_pkg::xlen - 21){id_word.j.imm20}}, // sign fill
        id_word.j.imm20,
        id_word.j.imm19_12,
        id_word.j.imm11,
        id_word.j.imm10_1,
        1'b0
    };

    assign jal_target = id_pc + jal_offset;       // pc relative

    ////////////////////////////////////////////////////////////////////////
    // redirect merge
    ////////////////////////////////////////////////////////////////////////

    // the later stage is older, so its redirect beats our jal
    assign take_branch   = redirect || jal_taken;
    assign branch_target = redirect ? redirect_target : jal_target;

endmodule

// File: logic/fetch_top.sv
////////////////////////////////////////////////////////////////////////////
// front end top: instruction memory, fetch, decode predecode
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_top (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 stall,           // from hazard unit
    input  logic                                 stall_load,      // from hazard unit
    input  logic                                 redirect,        // later stage branch
    input  logic [fetch_pkg::xlen-1:0]           redirect_target,
    input  logic                                 load_enable,     // memory fill
    input  logic [fetch_pkg::imem_addr_bits-1:0] load_addr,
    input  logic [63:0]                          load_data,
    output logic                                 id_valid,
    output logic [fetch_pkg::xlen-1:0]           id_pc,
    output logic [fetch_pkg::xlen-1:0]           id_npc,
    output logic [31:0]                          id_inst,
    output logic                                 take_branch
);

    // fetch <-> memory
    logic [fetch_pkg::xlen-1:0] imem_addr;
    logic [63:0]                imem_data;

    // fetch -> decode packet
    logic                       if_valid;
    logic [fetch_pkg::xlen-1:0] if_pc;
    logic [fetch_pkg::xlen-1:0] if_npc;
    logic [31:0]                if_inst;

    logic [fetch_pkg::xlen-1:0] branch_target; // decode -> fetch

    imem imem_i (
        .clock       (clock),
        .reset       (reset),
        .load_enable (load_enable),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .addr        (imem_addr),
        .data        (imem_data)
    );

    stage_if stage_if_i (
        .clock         (clock),
        .reset         (reset),
        .stall         (stall),
        .stall_load    (stall_load),
        .take_branch   (take_branch),
        .branch_target (branch_target),
        .imem_data     (imem_data),
        .imem_addr     (imem_addr),
        .if_valid      (if_valid),
        .if_pc         (if_pc),
        .if_npc        (if_npc),
        .if_inst       (if_inst)
    );

    stage_id_predecode stage_id_i (
        .clock           (clock),
        .reset           (reset),
        .stall_load      (stall_load),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .if_valid        (if_valid),
        .if_pc           (if_pc),
        .if_npc          (if_npc),
        .if_inst         (if_inst),
        .id_valid        (id_valid),
        .id_pc           (id_pc),
        .id_npc          (id_npc),
        .id_inst         (id_inst),
        .take_branch     (take_branch),
        .branch_target   (branch_target)
    );

endmodule

// File: tests/fetch_asserts.sv
////////////////////////////////////////////////////////////////////////////
// concurrent checks on the if/id packet, bound into stage_if
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_asserts (
    input logic                       clock,
    input logic                       reset,
    input logic                       stall_load,
    input logic                       take_branch,
    input logic                       if_valid,
    input logic [fetch_pkg::xlen-1:0] if_pc,
    input logic [fetch_pkg::xlen-1:0] if_npc,
    input logic [31:0]                if_inst
);

    // reset or a squash leaves a bubble in the packet
    bubble_after_squash: assert property (
        @(posedge clock) (reset || take_branch) |=> !if_valid
    ) else $error("if_valid high right after reset or take_branch");

    // sequential next pc travels with every valid packet
    npc_follows_pc: assert property (
        @(posedge clock) disable iff (reset)
        if_valid |-> (if_npc == if_pc + 32'd4)
    ) else $error("if_npc is not if_pc plus 4");

    // load hold freezes the whole packet
    packet_held: assert property (
        @(posedge clock) disable iff (reset)
        (stall_load && !take_branch) |=>
            ($stable(if_valid) && $stable(if_pc) && $stable(if_npc) && $stable(if_inst))
    ) else $error("packet changed during stall_load");

endmodule

bind stage_if fetch_asserts fetch_asserts_i (
    .clock       (clock),
    .reset       (reset),
    .stall_load  (stall_load),
    .take_branch (take_branch),
    .if_valid    (if_valid),
    .if_pc       (if_pc),
    .if_npc      (if_npc),
    .if_inst     (if_inst)
);

// File: tests/fetch_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the fetch front end driven by a vectors data file
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_tb;

    localparam string vectors_file  = "tests/fetch_vectors.txt";
    localparam int    file_words    = 1024; // room for image plus records
    localparam int    line_fields   = 2;    // low word, high word
    localparam int    record_fields = 9;    // 4 inputs, 5 expected outputs
    localparam int    reset_cycles  = 16;
    localparam int    timeout_slack = 40;   // cycles allowed past the last vector
    localparam int    check_delay   = 40;   // ns after the falling edge

    logic                                 clock;
    logic                                 reset;
    logic                                 stall;
    logic                                 stall_load;
    logic                                 redirect;
    logic [fetch_pkg::xlen-1:0]           redirect_target;
    logic                                 load_enable;
    logic [fetch_pkg::imem_addr_bits-1:0] load_addr;
    logic [63:0]                          load_data;
    logic                                 id_valid;
    logic [fetch_pkg::xlen-1:0]           id_pc;
    logic [fetch_pkg::xlen-1:0]           id_npc;
    logic [31:0]                          id_inst;
    logic                                 take_branch;

    logic [31:0] words [file_words];  // every token of the vectors file
    int          image_lines;
    int          record_count;
    int          record_base;         // first field of record 0
    int          cycle_count;
    int          cycle_limit;
    int          vector_index;        // record under check, for messages

    initial clock = 1'b0;
    always #50 clock = ~clock;        // 100 ns period

    fetch_top dut_i (
        .clock           (clock),
        .reset           (reset),
        .stall           (stall),
        .stall_load      (stall_load),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .load_enable     (load_enable),
        .load_addr       (load_addr),
        .load_data       (load_data),
        .id_valid        (id_valid),
        .id_pc           (id_pc),
        .id_npc          (id_npc),
        .id_inst         (id_inst),
        .take_branch     (take_branch)
    );

    ////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "run stopped: %s", reason);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h actual %h at vector %0d",
                     name, expected, actual, vector_index);
            abort_run("output mismatch");
        end
    endtask

    // tokens in order are image count, image rows, record count and records
    task automatic read_vectors();
        $readmemh(vectors_file, words);
        image_lines  = int'(words[0]);
        record_base  = 1 + line_fields * image_lines + 1;
        record_count = int'(words[record_base - 1]);
        if (image_lines < 1 || image_lines > reset_cycles) begin
            abort_run("memory image is missing or longer than the reset period");
        end else if (record_count < 1) begin
            abort_run("vectors file holds no stimulus records");
        end
        cycle_limit = reset_cycles + record_count + timeout_slack;
    endtask

    // one line per falling edge while reset is high
    task automatic load_image();
        for (int i = 0; i < reset_cycles; i++) begin
            if (i > 0) begin
                @(negedge clock);
            end
            if (i < image_lines) begin
                load_enable = 1'b1;
                load_addr   = fetch_pkg::imem_addr_bits'(i);
                load_data   = {words[1 + line_fields * i + 1], words[1 + line_fields * i]};
            end else begin
                load_enable = 1'b0;            // image shorter than reset
                load_data   = '0;
            end
        end
    endtask

    task automatic apply_vector(input int base);
        stall           = words[base][0];
        stall_load      = words[base + 1][0];
        redirect        = words[base + 2][0];
        redirect_target = words[base + 3];
    endtask

    task automatic check_vector(input int base);
        check_value("id_valid",    words[base + 4], 32'(id_valid));
        check_value("id_pc",       words[base + 5], id_pc);
        check_value("id_npc",      words[base + 6], id_npc);
        check_value("id_inst",     words[base + 7], id_inst);
        check_value("take_branch", words[base + 8], 32'(take_branch));
    endtask

    ////////////////////////////////////////////////////////////////////////
    // run
    ////////////////////////////////////////////////////////////////////////

    // watchdog counts rising edges against the limit from the vectors
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("run timed out after %0d cycles before the last vector", cycle_count);
            abort_run("timeout");
        end
    end

    initial begin
        reset           = 1'b1;
        stall           = 1'b0;
        stall_load      = 1'b0;
        redirect        = 1'b0;
        redirect_target = '0;
        load_enable     = 1'b0;
        load_addr       = '0;
        load_data       = '0;
        cycle_count     = 0;
        cycle_limit     = reset_cycles + timeout_slack;
        vector_index    = 0;

        read_vectors();
        load_image();

        @(negedge clock);
        reset       = 1'b0;
        load_enable = 1'b0;

        // drive at the falling edge, check just before the rising one
        for (int k = 0; k < record_count; k++) begin
            if (k > 0) begin
                @(negedge clock);
            end
            vector_index = k;
            apply_vector(record_base + k * record_fields);
            #(check_delay);
            check_vector(record_base + k * record_fields);
        end

        // any mismatch has already stopped the run
        $display("** PASS **");
        $finish;
    end

endmodule

// File: tests/fetch_vectors.txt
// image: line count, then per line the low word (pc) and high word (pc+4)
// records: stall stall_load redirect redirect_target valid pc npc inst take_branch
// every value is hex, one record per clock cycle after reset
00000010
00000093 00400093
00800093 00C00093
01000093 01400093
01800093 01C00093
020000EF 02400093
02800093 02C00093
03000093 03400093
03800093 03C00093
04000093 04400093
FDDFF0EF 04C00093
05000093 05400093
05800093 05C00093
06000093 06400093
010000EF 06C00093
07000093 07400093
07800093 07C00093
// stimulus record count
00000030
// out of reset, then sequential fetch
0 0 0 00000000  0 00000000 00000004 00000013 0
0 0 0 00000000  0 00000000 00000004 00000013 0
0 0 0 00000000  1 00000000 00000004 00000093 0
0 0 0 00000000  1 00000004 00000008 00400093 0
// stall for two cycles
1 0 0 00000000  1 00000008 0000000C 00800093 0
1 0 0 00000000  1 0000000C 00000010 00C00093 0
0 0 0 00000000  0 00000010 00000014 00000013 0
0 0 0 00000000  0 00000010 00000014 00000013 0
0 0 0 00000000  1 00000010 00000014 01000093 0
// load hold with stall
1 1 0 00000000  1 00000014 00000018 01400093 0
1 1 0 00000000  1 00000014 00000018 01400093 0
1 1 0 00000000  1 00000014 00000018 01400093 0
0 0 0 00000000  1 00000014 00000018 01400093 0
0 0 0 00000000  1 00000018 0000001C 01800093 0
0 0 0 00000000  1 0000001C 00000020 01C00093 0
// jal +0x20 at 0x20
0 0 0 00000000  1 00000020 00000024 020000EF 1
0 0 0 00000000  0 00000000 00000004 00000013 0
0 0 0 00000000  0 00000000 00000004 00000013 0
0 0 0 00000000  1 00000040 00000044 04000093 0
0 0 0 00000000  1 00000044 00000048 04400093 0
// jal -0x24 at 0x48
0 0 0 00000000  1 00000048 0000004C FDDFF0EF 1
0 0 0 00000000  0 00000000 00000004 00000013 0
0 0 0 00000000  0 00000000 00000004 00000013 0
0 0 0 00000000  1 00000024 00000028 02400093 0
// external redirect to 0x60
0 0 1 00000060  1 00000028 0000002C 02800093 1
0 0 0 00000000  0 00000000 00000004 00000013 0
0 0 0 00000000  0 00000000 00000004 00000013 0
0 0 0 00000000  1 00000060 00000064 06000093 0
0 0 0 00000000  1 00000064 00000068 06400093 0
// redirect to 0x50 beats the jal at 0x68
0 0 1 00000050  1 00000068 0000006C 010000EF 1
0 0 0 00000000  0 00000000 00000004 00000013 0
0 0 0 00000000  0 00000000 00000004 00000013 0
0 0 0 00000000  1 00000050 00000054 05000093 0
0 0 0 00000000  1 00000054 00000058 05400093 0
0 0 0 00000000  1 00000058 0000005C 05800093 0
0 0 0 00000000  1 0000005C 00000060 05C00093 0
0 0 0 00000000  1 00000060 00000064 06000093 0
0 0 0 00000000  1 00000064 00000068 06400093 0
// jal +0x10 at 0x68 taken while stall is high
1 0 0 00000000  1 00000068 0000006C 010000EF 1
0 0 0 00000000  0 00000000 00000004 00000013 0
0 0 0 00000000  0 00000000 00000004 00000013 0
0 0 0 00000000  1 00000078 0000007C 07800093 0
// redirect back to 0 before running off the image
0 0 1 00000000  1 0000007C 00000080 07C00093 1
0 0 0 00000000  0 00000000 00000004 00000013 0
0 0 0 00000000  0 00000000 00000004 00000013 0
0 0 0 00000000  1 00000000 00000004 00000093 0
0 0 0 00000000  1 00000004 00000008 00400093 0
0 0 0 00000000  1 00000008 0000000C 00800093 0

// File: verilog.f
logic/fetch_pkg.sv
logic/imem.sv
logic/stage_if.sv
logic/stage_id_predecode.sv
logic/fetch_top.sv
tests/fetch_asserts.sv
tests/fetch_tb.sv

// File: Makefile
# verilator build and run for the fetch front end

VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = fetch_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
PASS_TEXT = \*\* PASS \*\*

SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides, the simulator exit status is not trusted
run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q '^$(PASS_TEXT)$$' $(LOG) || { echo "simulation did not pass"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
